/* wired_axi_pkg.sv */
package wired_axi_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus widths and fixed transaction ids
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int axi_id_w   = 4;
  localparam int axi_addr_w = 32;
  localparam int axi_data_w = 32;
  localparam int axi_strb_w = axi_data_w / 8;

  localparam logic [axi_id_w-1:0] id_fetch = 4'd0;
  localparam logic [axi_id_w-1:0] id_load  = 4'd1;
  localparam logic [axi_id_w-1:0] id_store = 4'd2;

  // Every transaction is a single 32-bit beat
  localparam logic [7:0] axi_len_single = 8'd0;
  localparam logic [2:0] axi_size_word  = 3'd2;
  localparam logic [1:0] axi_burst_incr = 2'b01;

  localparam logic [31:0] reset_pc   = 32'h0000_0000;
  localparam logic [31:0] irq_vector = 32'h0000_0100;
  localparam int          num_regs   = 16;  // Register 0 always reads as zero

  typedef enum logic [1:0] {
    okay   = 2'b00,
    exokay = 2'b01,
    slverr = 2'b10,
    decerr = 2'b11
  } axi_resp_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction set
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Word layout is opcode in 31:28, rd in 27:24, rs in 23:20, rt in 19:16
  // and a sign-extended 16-bit immediate in 15:0
  typedef enum logic [3:0] {
    op_nop  = 4'd0,
    op_addi = 4'd1,  // rd = rs + imm
    op_add  = 4'd2,  // rd = rs + rt
    op_lw   = 4'd3,  // rd = mem[rs + imm]
    op_sw   = 4'd4,  // mem[rs + imm] = rt
    op_beq  = 4'd5,  // Branch to pc + 4 + imm * 4 when rs equals rt
    op_reti = 4'd6   // Return from the interrupt handler
  } opcode_t;

  typedef enum logic [2:0] {
    st_fetch,
    st_fetch_wait,
    st_exec,
    st_mem_wait,
    st_irq
  } core_state_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // AXI channels
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic [axi_id_w-1:0]   id;
    logic [axi_addr_w-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
    logic [1:0]            lock;
    logic [3:0]            cache;
    logic [2:0]            prot;
  } axi_ar_t;

  typedef struct packed {
    logic [axi_id_w-1:0]   id;
    logic [axi_addr_w-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
    logic [1:0]            lock;
    logic [3:0]            cache;
    logic [2:0]            prot;
  } axi_aw_t;

  typedef struct packed {
    logic [axi_data_w-1:0] data;
    logic [axi_strb_w-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [axi_id_w-1:0]   id;
    logic [axi_data_w-1:0] data;
    axi_resp_t             resp;
    logic                  last;
  } axi_r_t;

  typedef struct packed {
    logic [axi_id_w-1:0] id;
    axi_resp_t           resp;
  } axi_b_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Core side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic                  write;
    logic                  fetch;  // Marks a read as an instruction fetch
    logic [axi_addr_w-1:0] addr;
    logic [axi_data_w-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [axi_data_w-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [3:0]  rf_wen;
    logic [4:0]  rf_wnum;
    logic [31:0] rf_wdata;
  } wb_trace_t;

endpackage

/* axi_host_port.sv */
`timescale 1ns/1ns

module axi_host_port (
  input  logic                    aclk,
  input  logic                    reset,
  input  logic                    mem_req_valid,
  input  wired_axi_pkg::mem_req_t mem_req,
  output logic                    mem_done,
  output wired_axi_pkg::mem_rsp_t mem_rsp,
  output wired_axi_pkg::axi_ar_t  ar,
  output logic                    ar_valid,
  input  logic                    ar_ready,
  input  wired_axi_pkg::axi_r_t   r,
  input  logic                    r_valid,
  output logic                    r_ready,
  output wired_axi_pkg::axi_aw_t  aw,
  output logic                    aw_valid,
  input  logic                    aw_ready,
  output wired_axi_pkg::axi_w_t   w,
  output logic                    w_valid,
  input  logic                    w_ready,
  input  wired_axi_pkg::axi_b_t   b,
  input  logic                    b_valid,
  output logic                    b_ready
);

  typedef enum logic [1:0] {
    hp_idle,
    hp_addr,
    hp_resp,
    hp_done
  } port_state_t;

  port_state_t state;
  logic        is_write;
  logic        launch;
  logic        aw_done;
  logic        w_done;

  assign launch  = (state == hp_idle) && mem_req_valid;
  assign aw_done = !aw_valid || aw_ready;  // Address already gone or leaving now
  assign w_done  = !w_valid || w_ready;

  assign r_ready  = (state == hp_resp) && !is_write;
  assign b_ready  = (state == hp_resp) && is_write;
  assign mem_done = (state == hp_done);

  always_ff @(posedge aclk) begin
    if (reset) begin
      state    <= hp_idle;
      is_write <= 1'b0;
      ar_valid <= 1'b0;
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
    end else begin
      case (state)
        hp_idle: if (launch) begin
          is_write <= mem_req.write;
          ar_valid <= !mem_req.write;
          aw_valid <= mem_req.write;
          w_valid  <= mem_req.write;
          state    <= hp_addr;
        end
        hp_addr: begin
          if (is_write) begin
            if (aw_ready) aw_valid <= 1'b0;
            if (w_ready) w_valid <= 1'b0;
            if (aw_done && w_done) state <= hp_resp;
          end else if (ar_ready) begin
            ar_valid <= 1'b0;
            state    <= hp_resp;
          end
        end
        hp_resp: begin
          if (is_write && b_valid) state <= hp_done;  // Response code is not checked
          if (!is_write && r_valid && r.last) state <= hp_done;
        end
        default: state <= hp_idle;  // Core drops its request on this cycle
      endcase
    end
  end

  // Channel payloads only change while the port is idle
  always_ff @(posedge aclk) begin
    if (launch) begin
      ar.id    <= mem_req.fetch ? wired_axi_pkg::id_fetch : wired_axi_pkg::id_load;
      ar.addr  <= mem_req.addr;
      ar.len   <= wired_axi_pkg::axi_len_single;
      ar.size  <= wired_axi_pkg::axi_size_word;
      ar.burst <= wired_axi_pkg::axi_burst_incr;
      ar.lock  <= 2'b00;
      ar.cache <= 4'b0000;
      ar.prot  <= {mem_req.fetch, 2'b00};  // Instruction access flag
      aw.id    <= wired_axi_pkg::id_store;
      aw.addr  <= mem_req.addr;
      aw.len   <= wired_axi_pkg::axi_len_single;
      aw.size  <= wired_axi_pkg::axi_size_word;
      aw.burst <= wired_axi_pkg::axi_burst_incr;
      aw.lock  <= 2'b00;
      aw.cache <= 4'b0000;
      aw.prot  <= 3'b000;
      w.data   <= mem_req.wdata;
      w.strb   <= '1;
      w.last   <= 1'b1;
    end
    if (r_ready && r_valid) mem_rsp.rdata <= r.data;
  end

endmodule

/* tiny_core.sv */
`timescale 1ns/1ns

module tiny_core (
  input  logic                     aclk,
  input  logic                     reset,
  input  logic [7:0]               intrpt,
  output logic                     mem_req_valid,
  output wired_axi_pkg::mem_req_t  mem_req,
  input  logic                     mem_done,
  input  wired_axi_pkg::mem_rsp_t  mem_rsp,
  output wired_axi_pkg::wb_trace_t wb_trace
);

  wired_axi_pkg::core_state_t state;
  logic [31:0] pc;
  logic [31:0] epc;  // Return address for op_reti
  logic        ie;   // Interrupt enable
  logic [31:0] ir;
  logic [31:0] rf [wired_axi_pkg::num_regs];

  wired_axi_pkg::opcode_t op;
  logic [3:0]  rd;
  logic [3:0]  rs;
  logic [3:0]  rt;
  logic [31:0] imm;
  logic [31:0] rs_val;
  logic [31:0] rt_val;
  logic        irq_take;
  logic        wb_en;
  logic [31:0] wb_data;

  assign op  = wired_axi_pkg::opcode_t'(ir[31:28]);
  assign rd  = ir[27:24];
  assign rs  = ir[23:20];
  assign rt  = ir[19:16];
  assign imm = {{16{ir[15]}}, ir[15:0]};

  assign rs_val = (rs == 4'd0) ? 32'd0 : rf[rs];
  assign rt_val = (rt == 4'd0) ? 32'd0 : rf[rt];

  // Interrupts are only looked at on the instruction boundary
  assign irq_take = ie && (intrpt != 8'd0);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Memory requests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    mem_req_valid = 1'b0;
    mem_req       = '0;
    case (state)
      wired_axi_pkg::st_fetch, wired_axi_pkg::st_fetch_wait: begin
        mem_req_valid = (state == wired_axi_pkg::st_fetch_wait) || !irq_take;
        mem_req.fetch = 1'b1;
        mem_req.addr  = pc;
      end
      wired_axi_pkg::st_mem_wait: begin
        mem_req_valid = 1'b1;
        mem_req.write = (op == wired_axi_pkg::op_sw);
        mem_req.addr  = rs_val + imm;
        mem_req.wdata = rt_val;
      end
      default: ;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Writeback and trace
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    wb_en   = 1'b0;
    wb_data = 32'd0;
    if (state == wired_axi_pkg::st_exec) begin
      if (op == wired_axi_pkg::op_addi) begin
        wb_en   = 1'b1;
        wb_data = rs_val + imm;
      end else if (op == wired_axi_pkg::op_add) begin
        wb_en   = 1'b1;
        wb_data = rs_val + rt_val;
      end
    end else if (state == wired_axi_pkg::st_mem_wait && mem_done &&
                 op == wired_axi_pkg::op_lw) begin
      wb_en   = 1'b1;
      wb_data = mem_rsp.rdata;
    end
  end

  assign wb_trace.pc       = pc;
  assign wb_trace.rf_wen   = {4{wb_en}};
  assign wb_trace.rf_wnum  = wb_en ? {1'b0, rd} : 5'd0;
  assign wb_trace.rf_wdata = (wb_en && rd != 4'd0) ? wb_data : 32'd0;  // r0 traced as zero

  always_ff @(posedge aclk) begin
    if (wb_en && rd != 4'd0) rf[rd] <= wb_data;
    if (state == wired_axi_pkg::st_fetch_wait && mem_done) ir <= mem_rsp.rdata;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge aclk) begin
    if (reset) begin
      state <= wired_axi_pkg::st_fetch;
      pc    <= wired_axi_pkg::reset_pc;
      epc   <= wired_axi_pkg::reset_pc;
      ie    <= 1'b1;
    end else begin
      case (state)
        wired_axi_pkg::st_fetch:
          state <= irq_take ? wired_axi_pkg::st_irq : wired_axi_pkg::st_fetch_wait;
        wired_axi_pkg::st_fetch_wait:
          if (mem_done) state <= wired_axi_pkg::st_exec;
        wired_axi_pkg::st_exec: begin
          state <= wired_axi_pkg::st_fetch;
          pc    <= pc + 32'd4;
          case (op)
            wired_axi_pkg::op_lw, wired_axi_pkg::op_sw: begin
              state <= wired_axi_pkg::st_mem_wait;  // pc moves on once memory answers
              pc    <= pc;
            end
            wired_axi_pkg::op_beq:
              if (rs_val == rt_val) pc <= pc + 32'd4 + {imm[29:0], 2'b00};
            wired_axi_pkg::op_reti: begin
              pc <= epc;
              ie <= 1'b1;
            end
            default: ;  // op_nop and unused codes just advance
          endcase
        end
        wired_axi_pkg::st_mem_wait:
          if (mem_done) begin
            state <= wired_axi_pkg::st_fetch;
            pc    <= pc + 32'd4;
          end
        default: begin
          // Interrupt entry, pc already points at the next instruction
          epc   <= pc;
          ie    <= 1'b0;
          pc    <= wired_axi_pkg::irq_vector;
          state <= wired_axi_pkg::st_fetch;
        end
      endcase
    end
  end

endmodule

/* core_top.sv */
`timescale 1ns/1ns

module core_top (
  input  logic        aclk,
  input  logic        reset,
  input  logic [7:0]  intrpt,
  // Read address
  output logic [3:0]  arid,
  output logic [31:0] araddr,
  output logic [7:0]  arlen,
  output logic [2:0]  arsize,
  output logic [1:0]  arburst,
  output logic [1:0]  arlock,
  output logic [3:0]  arcache,
  output logic [2:0]  arprot,
  output logic        arvalid,
  input  logic        arready,
  // Read data
  input  logic [3:0]  rid,
  input  logic [31:0] rdata,
  input  logic [1:0]  rresp,
  input  logic        rlast,
  input  logic        rvalid,
  output logic        rready,
  // Write address
  output logic [3:0]  awid,
  output logic [31:0] awaddr,
  output logic [7:0]  awlen,
  output logic [2:0]  awsize,
  output logic [1:0]  awburst,
  output logic [1:0]  awlock,
  output logic [3:0]  awcache,
  output logic [2:0]  awprot,
  output logic        awvalid,
  input  logic        awready,
  // Write data
  output logic [3:0]  wid,
  output logic [31:0] wdata,
  output logic [3:0]  wstrb,
  output logic        wlast,
  output logic        wvalid,
  input  logic        wready,
  // Write response
  input  logic [3:0]  bid,
  input  logic [1:0]  bresp,
  input  logic        bvalid,
  output logic        bready,
  // Writeback trace
  output logic [31:0] debug_wb_pc,
  output logic [3:0]  debug_wb_rf_wen,
  output logic [4:0]  debug_wb_rf_wnum,
  output logic [31:0] debug_wb_rf_wdata
);

  logic reset_q;

  wired_axi_pkg::mem_req_t  mem_req;
  wired_axi_pkg::mem_rsp_t  mem_rsp;
  logic                     mem_req_valid;
  logic                     mem_done;
  wired_axi_pkg::wb_trace_t wb_trace;

  wired_axi_pkg::axi_ar_t ar;
  wired_axi_pkg::axi_aw_t aw;
  wired_axi_pkg::axi_w_t  w;
  wired_axi_pkg::axi_r_t  r;
  wired_axi_pkg::axi_b_t  b;
  logic [3:0]             aw_id_q;

  always_ff @(posedge aclk) reset_q <= reset;  // Pin reset registered once

  tiny_core i_tiny_core (
    .aclk          (aclk),
    .reset         (reset_q),
    .intrpt        (intrpt),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_done      (mem_done),
    .mem_rsp       (mem_rsp),
    .wb_trace      (wb_trace)
  );

  axi_host_port i_axi_host_port (
    .aclk          (aclk),
    .reset         (reset_q),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_done      (mem_done),
    .mem_rsp       (mem_rsp),
    .ar            (ar),
    .ar_valid      (arvalid),
    .ar_ready      (arready),
    .r             (r),
    .r_valid       (rvalid),
    .r_ready       (rready),
    .aw            (aw),
    .aw_valid      (awvalid),
    .aw_ready      (awready),
    .w             (w),
    .w_valid       (wvalid),
    .w_ready       (wready),
    .b             (b),
    .b_valid       (bvalid),
    .b_ready       (bready)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Channel structs to AXI3 pins
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign arid    = ar.id;
  assign araddr  = ar.addr;
  assign arlen   = ar.len;
  assign arsize  = ar.size;
  assign arburst = ar.burst;
  assign arlock  = ar.lock;
  assign arcache = ar.cache;
  assign arprot  = ar.prot;

  assign awid    = aw.id;
  assign awaddr  = aw.addr;
  assign awlen   = aw.len;
  assign awsize  = aw.size;
  assign awburst = aw.burst;
  assign awlock  = aw.lock;
  assign awcache = aw.cache;
  assign awprot  = aw.prot;

  // AXI3 slaves want a write data id, the core only knows the address id
  always_ff @(posedge aclk) begin
    if (awvalid) aw_id_q <= aw.id;
  end
  assign wid = awvalid ? aw.id : aw_id_q;

  assign wdata = w.data;
  assign wstrb = w.strb;
  assign wlast = w.last;

  assign r.id   = rid;
  assign r.data = rdata;
  assign r.resp = wired_axi_pkg::axi_resp_t'(rresp);
  assign r.last = rlast;
  assign b.id   = bid;
  assign b.resp = wired_axi_pkg::axi_resp_t'(bresp);

  assign debug_wb_pc       = wb_trace.pc;
  assign debug_wb_rf_wen   = wb_trace.rf_wen;
  assign debug_wb_rf_wnum  = wb_trace.rf_wnum;
  assign debug_wb_rf_wdata = wb_trace.rf_wdata;

endmodule

/* tb_axi_memory.sv */
`timescale 1ns/1ns

module tb_axi_memory (
  input  logic        aclk,
  input  logic        reset,
  input  logic [3:0]  delay_bits,  // Fresh random bits every cycle
  input  logic [3:0]  arid,
  input  logic [31:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [3:0]  rid,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rlast,
  output logic        rvalid,
  input  logic        rready,
  input  logic [3:0]  awid,
  input  logic [31:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic        wvalid,
  output logic        wready,
  output logic [3:0]  bid,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready
);

  logic [31:0] mem [1024];  // 4 KB indexed by addr[11:2]
  logic        aw_seen, w_seen, r_wait, b_wait;
  logic [1:0]  r_delay, b_delay;
  logic [31:0] aw_addr_q, w_data_q;
  logic [3:0]  aw_id_q;

  initial begin
    {arready, awready, wready, rvalid, bvalid, rlast} = '0;
    {rid, bid, rresp, bresp, rdata} = '0;
  end

  always @(posedge aclk) begin
    logic ar_hs, r_hs, aw_hs, w_hs, b_hs;
    logic [3:0]  bits, ar_id;
    logic [31:0] ar_addr, aw_addr, w_dat;
    logic [3:0]  aw_id;
    ar_hs = arvalid && arready;
    r_hs  = rvalid && rready;
    aw_hs = awvalid && awready;
    w_hs  = wvalid && wready;
    b_hs  = bvalid && bready;
    bits  = delay_bits;
    ar_id = arid;
    ar_addr = araddr;
    aw_addr = awaddr;
    aw_id   = awid;
    w_dat   = wdata;
    #2;
    if (reset) begin
      {arready, awready, wready, rvalid, bvalid} = '0;
      {aw_seen, w_seen, r_wait, b_wait} = '0;
    end else begin
      if (r_hs) rvalid = 1'b0;
      if (b_hs) bvalid = 1'b0;
      if (ar_hs) begin
        rid     = ar_id;
        rdata   = mem[ar_addr[11:2]];
        r_wait  = 1'b1;
        r_delay = bits[3:2];
      end else if (r_wait) begin
        if (r_delay == 2'd0) begin
          rvalid = 1'b1;
          rresp  = 2'b00;
          rlast  = 1'b1;
          r_wait = 1'b0;
        end else r_delay = r_delay - 2'd1;
      end
      if (aw_hs) begin
        aw_seen   = 1'b1;
        aw_addr_q = aw_addr;
        aw_id_q   = aw_id;
      end
      if (w_hs) begin
        w_seen   = 1'b1;
        w_data_q = w_dat;
      end
      if (aw_seen && w_seen) begin  // Commit the store once address and data are both in
        mem[aw_addr_q[11:2]] = w_data_q;
        {aw_seen, w_seen} = '0;
        b_wait  = 1'b1;
        b_delay = bits[1:0];
      end else if (b_wait) begin
        if (b_delay == 2'd0) begin
          bvalid = 1'b1;
          bid    = aw_id_q;
          bresp  = 2'b00;
          b_wait = 1'b0;
        end else b_delay = b_delay - 2'd1;
      end
      arready = bits[0];
      awready = bits[1];
      wready  = bits[2];
    end
  end

endmodule

/* tb_core_top.sv */
`timescale 1ns/1ns

module tb_core_top;

  logic aclk, reset;
  logic [7:0]  intrpt;
  logic [3:0]  delay_bits;
  logic [3:0]  arid, rid, awid, wid, bid, wstrb, arcache, awcache, debug_wb_rf_wen;
  logic [31:0] araddr, rdata, awaddr, wdata, debug_wb_pc, debug_wb_rf_wdata;
  logic [7:0]  arlen, awlen;
  logic [2:0]  arsize, arprot, awsize, awprot;
  logic [1:0]  arburst, arlock, awburst, awlock, rresp, bresp;
  logic [4:0]  debug_wb_rf_wnum;
  logic arvalid, arready, rlast, rvalid, rready, awvalid, awready;
  logic wlast, wvalid, wready, bvalid, bready;

  logic [31:0] lfsr;
  logic [31:0] model_mem [1024];
  logic [31:0] model_rf [16];
  logic [31:0] model_pc, model_epc, load_addr;
  logic        in_handler, expect_load, reti_seen, prev_reset_q;
  int          model_count, loop_count, irq_at;
  int          err_trace, err_store, err_read, err_other;
  wired_axi_pkg::wb_trace_t exp_trace [$];
  logic [31:0] exp_st_addr [$], exp_st_data [$], aw_q [$], w_q [$];
  logic [4:0]  w_ctl_q [$];  // strb and last of each accepted beat

  core_top i_core_top (.*);

  tb_axi_memory i_mem (
    .aclk(aclk), .reset(reset), .delay_bits(delay_bits),
    .arid(arid), .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rid(rid), .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready),
    .awid(awid), .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready)
  );

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  // Galois LFSR stepped once per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic [31:0] encode(input logic [3:0] op, input logic [3:0] rd,
                                         input logic [3:0] rs, input logic [3:0] rt,
                                         input logic [15:0] imm);
    return {op, rd, rs, rt, imm};
  endfunction

  task automatic check_trace(input wired_axi_pkg::wb_trace_t got,
                             input wired_axi_pkg::wb_trace_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED debug_wb: got pc %h wen %h wnum %h wdata %h, expected %h %h %h %h",
               got.pc, got.rf_wen, got.rf_wnum, got.rf_wdata,
               exp.pc, exp.rf_wen, exp.rf_wnum, exp.rf_wdata);
      err_trace++;
    end
  endtask

  task automatic check_store(input logic [31:0] addr, input logic [31:0] data,
                             input logic [4:0] ctl, input logic [31:0] exp_addr,
                             input logic [31:0] exp_data);
    if (addr !== exp_addr || data !== exp_data || ctl !== 5'h1f) begin
      $display("CHECK FAILED awaddr/wdata/wstrb,wlast: got %h %h %h, expected %h %h 1f",
               addr, data, ctl, exp_addr, exp_data);
      err_store++;
    end
  endtask

  task automatic check_fetch_id(input string name, input logic [3:0] got,
                                input logic [3:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      err_read++;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      err_other++;
    end
  endtask

  task automatic model_write(input logic [3:0] rd, input logic [31:0] val);
    wired_axi_pkg::wb_trace_t t;
    t.pc       = model_pc;
    t.rf_wen   = 4'hf;
    t.rf_wnum  = {1'b0, rd};
    t.rf_wdata = (rd == 4'd0) ? 32'd0 : val;
    if (rd != 4'd0) model_rf[rd] = val;
    exp_trace.push_back(t);
  endtask

  // Reference model that runs one instruction per observed fetch
  task automatic execute_model;
    logic [31:0] iw, a, b, imm, addr, next_pc;
    iw      = model_mem[model_pc[11:2]];
    a       = (iw[23:20] == 4'd0) ? 32'd0 : model_rf[iw[23:20]];
    b       = (iw[19:16] == 4'd0) ? 32'd0 : model_rf[iw[19:16]];
    imm     = {{16{iw[15]}}, iw[15:0]};
    addr    = a + imm;
    next_pc = model_pc + 32'd4;
    model_count++;
    case (iw[31:28])
      wired_axi_pkg::op_addi: model_write(iw[27:24], a + imm);
      wired_axi_pkg::op_add:  model_write(iw[27:24], a + b);
      wired_axi_pkg::op_lw: begin
        expect_load = 1'b1;
        load_addr   = addr;
        model_write(iw[27:24], model_mem[addr[11:2]]);
      end
      wired_axi_pkg::op_sw: begin
        exp_st_addr.push_back(addr);
        exp_st_data.push_back(b);
        model_mem[addr[11:2]] = b;
      end
      wired_axi_pkg::op_beq: if (a == b) next_pc = next_pc + imm * 32'd4;
      wired_axi_pkg::op_reti: begin
        next_pc    = model_epc;
        in_handler = 1'b0;
      end
      default: ;
    endcase
    if (next_pc == model_pc) loop_count++;
    model_pc = next_pc;
  endtask

  task automatic handle_read(input logic [3:0] id, input logic [31:0] addr);
    if (expect_load) begin
      check_fetch_id("arid", id, wired_axi_pkg::id_load);
      check_word("araddr", addr, load_addr);
      expect_load = 1'b0;
    end else begin
      if (intrpt != 8'd0 && !in_handler && addr == wired_axi_pkg::irq_vector) begin
        model_epc  = model_pc;
        model_pc   = wired_axi_pkg::irq_vector;
        in_handler = 1'b1;
      end
      check_fetch_id("arid", id, wired_axi_pkg::id_fetch);
      check_word("araddr", addr, model_pc);
      if (in_handler && model_pc == wired_axi_pkg::irq_vector + 32'd8) reti_seen = 1'b1;
      execute_model();
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus and trace monitor sampled on the rising edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge aclk) begin
    wired_axi_pkg::wb_trace_t got;
    got = {debug_wb_pc, debug_wb_rf_wen, debug_wb_rf_wnum, debug_wb_rf_wdata};
    if (i_core_top.reset_q === 1'b1 && prev_reset_q === 1'b1) begin
      check_word("arvalid/awvalid/wvalid/rready/bready/rf_wen in reset",
                 {26'd0, arvalid, awvalid, wvalid, rready, bready, |debug_wb_rf_wen}, 32'd0);
    end else if (i_core_top.reset_q === 1'b0) begin
      if (debug_wb_rf_wen !== 4'd0) begin
        if (exp_trace.size() == 0) begin
          $display("Register write seen at pc %h with no write expected", debug_wb_pc);
          err_trace++;
        end else check_trace(got, exp_trace.pop_front());
      end
      if (arvalid && arready) begin
        // Single beat of one word, INCR, with prot bit 2 set for an instruction fetch
        check_word("arlen/arsize/arburst/arlock/arcache/arprot",
                   {10'd0, arlen, arsize, arburst, arlock, arcache, arprot},
                   {10'd0, 8'd0, 3'd2, 2'b01, 2'b00, 4'd0, !expect_load, 2'b00});
        handle_read(arid, araddr);
      end
      if (awvalid && awready) begin
        check_fetch_id("awid", awid, wired_axi_pkg::id_store);
        check_word("awlen/awsize/awburst/awlock/awcache/awprot",
                   {10'd0, awlen, awsize, awburst, awlock, awcache, awprot},
                   {10'd0, 8'd0, 3'd2, 2'b01, 2'b00, 4'd0, 3'd0});
        aw_q.push_back(awaddr);
      end
      if (wvalid && wready) begin
        check_fetch_id("wid", wid, wired_axi_pkg::id_store);
        w_q.push_back(wdata);
        w_ctl_q.push_back({wstrb, wlast});
      end
      if (aw_q.size() > 0 && w_q.size() > 0) begin
        if (exp_st_addr.size() == 0) begin
          $display("Store to %h seen with no store expected", aw_q[0]);
          err_store++;
          void'(aw_q.pop_front());
          void'(w_q.pop_front());
          void'(w_ctl_q.pop_front());
        end else begin
          check_store(aw_q.pop_front(), w_q.pop_front(), w_ctl_q.pop_front(),
                      exp_st_addr.pop_front(), exp_st_data.pop_front());
        end
      end
    end
    prev_reset_q = i_core_top.reset_q;
  end

  always @(posedge aclk) begin
    #2;
    delay_bits = 4'(rand_bits(4));
  end

  initial begin
    logic [31:0] r;
    logic [3:0]  rd, rs, rt;
    logic [15:0] imm;
    logic [7:0]  irq_val;
    int          cycles;
    lfsr = 32'd25;
    {reset, intrpt, delay_bits} = {1'b1, 8'd0, 4'd0};
    {err_trace, err_store, err_read, err_other} = '0;
    {model_count, loop_count} = '0;
    {in_handler, expect_load, reti_seen} = '0;
    model_pc = wired_axi_pkg::reset_pc;
    for (int k = 0; k < 1024; k++) model_mem[k] = rand_bits(32);
    for (int k = 0; k < 15; k++) begin  // Give every register a known value
      model_mem[k] = encode(wired_axi_pkg::op_addi, 4'(k + 1), 4'd0, 4'd0, 16'(rand_bits(16)));
    end
    for (int k = 15; k < 47; k++) begin
      r   = rand_bits(3);
      rd  = 4'(rand_bits(4));
      rs  = 4'(rand_bits(4));
      rt  = 4'(rand_bits(4));
      imm = 16'(rand_bits(16));
      case (r[2:0])
        3'd0: model_mem[k] = encode(wired_axi_pkg::op_nop, rd, rs, rt, imm);
        3'd1, 3'd6: model_mem[k] = encode(wired_axi_pkg::op_addi, rd, rs, rt, imm);
        3'd2, 3'd7: model_mem[k] = encode(wired_axi_pkg::op_add, rd, rs, rt, imm);
        3'd3, 3'd4: begin
          imm = 16'h0200 + {7'd0, imm[6:0], 2'b00};  // Data lives at 0x200 to 0x3fc
          model_mem[k] = encode(r[2:0] == 3'd3 ? wired_axi_pkg::op_lw : wired_axi_pkg::op_sw,
                                rd, 4'd0, rt, imm);
        end
        default: begin
          imm = {14'd0, imm[1:0]};
          if (imm > 16'(46 - k)) imm = 16'(46 - k);  // Forward only and inside the program
          model_mem[k] = encode(wired_axi_pkg::op_beq, rd, rs, rand_bits(1) ? rs : rt, imm);
        end
      endcase
    end
    model_mem[47] = encode(wired_axi_pkg::op_beq, 4'd0, 4'd0, 4'd0, 16'hffff);
    model_mem[64] = encode(wired_axi_pkg::op_addi, 4'd15, 4'd15, 4'd0, 16'd1);
    model_mem[65] = encode(wired_axi_pkg::op_addi, 4'd15, 4'd15, 4'd0, 16'd2);
    model_mem[66] = encode(wired_axi_pkg::op_reti, 4'd0, 4'd0, 4'd0, 16'd0);
    for (int k = 0; k < 1024; k++) i_mem.mem[k] = model_mem[k];
    irq_at  = 16 + int'(rand_bits(4));
    irq_val = 8'(rand_bits(8)) | 8'h01;

    repeat (5) @(posedge aclk);
    #2 reset = 1'b0;

    cycles = 0;
    while (model_count < irq_at && cycles < 20000) begin
      @(posedge aclk);
      cycles++;
    end
    if (model_count < irq_at) begin
      $display("Timed out waiting for the program to reach the interrupt point");
      err_other++;
    end else begin
      #2 intrpt = irq_val;
      cycles = 0;
      while (!reti_seen && cycles < 20000) begin
        @(posedge aclk);
        cycles++;
      end
      #2 intrpt = 8'd0;
      if (!reti_seen) begin
        $display("Timed out waiting for the interrupt handler to return");
        err_other++;
      end else begin
        cycles = 0;
        while ((loop_count < 3 || in_handler) && cycles < 40000) begin
          @(posedge aclk);
          cycles++;
        end
        if (loop_count < 3) begin
          $display("Timed out waiting for the program to reach its final loop");
          err_other++;
        end
      end
    end
    if (exp_trace.size() != 0 || exp_st_addr.size() != 0) begin
      $display("Expected register writes or stores were never seen");
      err_other++;
    end
    $display("Errors: trace %0d, store %0d, read %0d, other %0d",
             err_trace, err_store, err_read, err_other);
    if (err_trace + err_store + err_read + err_other == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* compile.f */
wired_axi_pkg.sv
axi_host_port.sv
tiny_core.sv
core_top.sv
tb_axi_memory.sv
tb_core_top.sv

/* Makefile */
# Verilator flow for the core_top testbench

VERILATOR ?= verilator
TOP       ?= tb_core_top
RTL_TOP   ?= core_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o sim_$(TOP)
	./$(BUILD_DIR)/sim_$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
